// File: Makefile
# Verilator build and run of the memory-access stage testbench.

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tb_lsu_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dbus_axil_bridge.sv
// *********************************************************************
// data bus to axi4-lite bridge
// runs one request/busy access as a single axi4-lite read or write.
// busy is high from the cycle after acceptance until the cycle after
// the response, when rdata and err are valid.
// *********************************************************************

`timescale 1ns/1ps

module dbus_axil_bridge (
    input  logic           CLK,
    input  logic           nRST,
    dbus_if.bridge         bus,
    output lsu_pkg::word_t awaddr,
    output logic [2:0]     awprot,
    output logic           awvalid,
    input  logic           awready,
    output lsu_pkg::word_t wdata,
    output logic [3:0]     wstrb,
    output logic           wvalid,
    input  logic           wready,
    input  logic           bvalid,
    input  logic [1:0]     bresp,
    output logic           bready,
    output lsu_pkg::word_t araddr,
    output logic [2:0]     arprot,
    output logic           arvalid,
    input  logic           arready,
    input  logic           rvalid,
    input  lsu_pkg::word_t rdata,
    input  logic [1:0]     rresp,
    output logic           rready
);

    typedef enum logic [2:0] {
        IDLE,
        WR_ADDR_DATA,
        WR_RESP,
        RD_ADDR,
        RD_DATA
    } state_t;

    state_t         state;
    state_t         state_next;
    logic           aw_pend;      // aw not yet accepted.
    logic           w_pend;       // w not yet accepted.
    logic           done_wait;    // finished access, request still up.
    logic           req;
    logic           accept;
    logic           b_fire;
    logic           r_fire;
    lsu_pkg::word_t addr_q;
    lsu_pkg::word_t wdata_q;
    logic [3:0]     strb_q;
    lsu_pkg::word_t rdata_q;
    logic           err_q;

    assign req    = bus.ren | bus.wen;
    assign accept = (state == IDLE) & req & ~done_wait;
    assign b_fire = bready & bvalid;
    assign r_fire = rready & rvalid;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:         if (accept) state_next = bus.wen ? WR_ADDR_DATA : RD_ADDR;
            WR_ADDR_DATA: if ((!aw_pend || awready) && (!w_pend || wready))
                              state_next = WR_RESP;
            WR_RESP:      if (bvalid) state_next = IDLE;
            RD_ADDR:      if (arready) state_next = RD_DATA;
            RD_DATA:      if (rvalid) state_next = IDLE;
            default:      state_next = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            aw_pend   <= 1'b0;
            w_pend    <= 1'b0;
            done_wait <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            state <= state_next;
            if (accept && bus.wen) begin
                aw_pend <= 1'b1;
                w_pend  <= 1'b1;
            end else begin
                if (awready) aw_pend <= 1'b0;   // each channel drops on its own.
                if (wready)  w_pend  <= 1'b0;
            end
            // keep the held request from starting a second access.
            if (b_fire || r_fire)
                done_wait <= 1'b1;
            else if (!req)
                done_wait <= 1'b0;
            if (b_fire) err_q <= (bresp != lsu_pkg::AXI_RESP_OKAY);
            if (r_fire) err_q <= (rresp != lsu_pkg::AXI_RESP_OKAY);
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
            strb_q  <= bus.byte_en;
        end
        if (r_fire) rdata_q <= rdata;
    end

    assign awaddr  = addr_q;
    assign awprot  = lsu_pkg::AXI_PROT_DATA;
    assign awvalid = aw_pend;
    assign wdata   = wdata_q;
    assign wstrb   = strb_q;
    assign wvalid  = w_pend;
    assign bready  = (state == WR_RESP);
    assign araddr  = addr_q;
    assign arprot  = lsu_pkg::AXI_PROT_DATA;
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    assign bus.busy  = (state != IDLE);
    assign bus.rdata = rdata_q;
    assign bus.err   = err_q;

    a_awaddr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        awvalid && !awready |=> $stable(awaddr))
        else $error("dbus_axil_bridge: awaddr changed under back-pressure");

endmodule

// File: dbus_if.sv
// *********************************************************************
// data bus interface
// request/busy bus between the load-store controller and the
// axi4-lite bridge. one access at a time, held until busy falls.
// *********************************************************************

`timescale 1ns/1ps

interface dbus_if;

    lsu_pkg::word_t addr;
    logic           ren;
    logic           wen;
    logic [3:0]     byte_en;
    lsu_pkg::word_t wdata;
    lsu_pkg::word_t rdata;   // valid when busy falls.
    logic           busy;
    logic           err;

    modport controller (
        output addr, ren, wen, byte_en, wdata,
        input  rdata, busy, err
    );

    modport bridge (
        input  addr, ren, wen, byte_en, wdata,
        output rdata, busy, err
    );

endinterface

// File: fence_flush_tracker.sv
// *********************************************************************
// fence flush tracker
// turns a rising instruction fence into one-cycle icache and dcache
// flush pulses and stalls the pipeline until both caches are done.
// *********************************************************************

`timescale 1ns/1ps

module fence_flush_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    output logic icache_flush,
    output logic dcache_flush,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic fence_stall
);

    logic ifence_q;
    logic fence_rise;
    logic iflushed;
    logic dflushed;

    assign fence_rise   = ifence & ~ifence_q;
    assign icache_flush = fence_rise;
    assign dcache_flush = fence_rise;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_q <= 1'b0;
            iflushed <= 1'b1;   // nothing pending out of reset.
            dflushed <= 1'b1;
        end else begin
            ifence_q <= ifence;
            // done wins over a pulse in the same cycle.
            if (iflush_done)
                iflushed <= 1'b1;
            else if (fence_rise)
                iflushed <= 1'b0;
            if (dflush_done)
                dflushed <= 1'b1;
            else if (fence_rise)
                dflushed <= 1'b0;
        end
    end

    assign fence_stall = ifence_q & ~(iflushed & dflushed);

    a_flush_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        icache_flush |=> !icache_flush)
        else $error("fence_flush_tracker: flush pulse longer than one cycle");

endmodule

// File: list.f
lsu_pkg.sv
dbus_if.sv
load_store_ctrl.sv
fence_flush_tracker.sv
dbus_axil_bridge.sv
lsu_top.sv
tb_axil_mem.sv
tb_lsu_top.sv

// File: load_store_ctrl.sv
// *********************************************************************
// load-store controller
// turns one scalar load or store into a data bus request: byte
// enables, store replication, lane mirroring for the bus byte order,
// misalignment check and sign/zero extension of load data.
// combinational from pipeline to bus and from bus to load_data.
// *********************************************************************

`timescale 1ns/1ps

module load_store_ctrl (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             ren,
    input  logic             wen,
    input  lsu_pkg::word_t   addr,
    input  lsu_pkg::access_t access,
    input  lsu_pkg::word_t   store_data,
    output lsu_pkg::word_t   load_data,
    output logic             ready,
    output logic             misaligned,
    output logic             bus_err,
    dbus_if.controller       bus
);

    logic [1:0]     offset;
    logic [3:0]     lane_en;      // natural lane order.
    logic [3:0]     wr_lane_en;   // lane order as the bus sees writes.
    lsu_pkg::word_t store_rep;
    lsu_pkg::word_t store_bus;
    logic [7:0]     load_byte;
    logic [15:0]    load_half;

    assign offset = addr[1:0];

    // lanes touched by the access.
    always_comb begin
        case (access)
            lsu_pkg::LB, lsu_pkg::LBU: lane_en = 4'b0001 << offset;
            lsu_pkg::LH, lsu_pkg::LHU: lane_en = offset[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::LW:               lane_en = 4'b1111;
            default:                   lane_en = 4'b0000;
        endcase
    end

    // halves need an even offset, words a zero offset.
    always_comb begin
        case (access)
            lsu_pkg::LH, lsu_pkg::LHU: misaligned = (ren | wen) & offset[0];
            lsu_pkg::LW:               misaligned = (ren | wen) & (offset != 2'b00);
            default:                   misaligned = 1'b0;
        endcase
    end

    // replicate so every lane the store may hit carries the data.
    always_comb begin
        case (access)
            lsu_pkg::LB, lsu_pkg::LBU: store_rep = {4{store_data[7:0]}};
            lsu_pkg::LH, lsu_pkg::LHU: store_rep = {2{store_data[15:0]}};
            default:                   store_rep = store_data;
        endcase
    end

    generate
        if (lsu_pkg::BUS_ENDIANNESS == "big") begin : g_bus_be
            assign wr_lane_en = lane_en;
            assign store_bus  = store_rep;
        end else begin : g_bus_le
            // lane i goes to lane 3-i on writes.
            assign wr_lane_en = {lane_en[0], lane_en[1], lane_en[2], lane_en[3]};
            assign store_bus  = (access == lsu_pkg::LW) ?
                                {store_rep[7:0], store_rep[15:8],
                                 store_rep[23:16], store_rep[31:24]} :
                                store_rep;
        end
    endgenerate

    // a misaligned access never reaches the bus.
    assign bus.addr    = addr;
    assign bus.ren     = ren & ~misaligned;
    assign bus.wen     = wen & ~misaligned;
    assign bus.byte_en = wen ? wr_lane_en : lane_en;   // loads are not mirrored.
    assign bus.wdata   = store_bus;

    // pick the addressed lanes out of the returned word.
    assign load_byte = bus.rdata[{offset, 3'b000} +: 8];
    assign load_half = offset[1] ? bus.rdata[31:16] : bus.rdata[15:0];

    always_comb begin
        case (access)
            lsu_pkg::LB:  load_data = {{24{load_byte[7]}}, load_byte};
            lsu_pkg::LBU: load_data = {24'h000000, load_byte};
            lsu_pkg::LH:  load_data = {{16{load_half[15]}}, load_half};
            lsu_pkg::LHU: load_data = {16'h0000, load_half};
            lsu_pkg::LW:  load_data = bus.rdata;
            default:      load_data = '0;
        endcase
    end

    assign ready   = ~bus.busy;
    assign bus_err = bus.err;

    // the pipeline issues a load or a store, never both.
    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen))
        else $error("load_store_ctrl: ren and wen high in the same cycle");

endmodule

// File: lsu_pkg.sv
// *********************************************************************
// lsu package
// shared types and constants for the memory-access stage: the data
// word, scalar access widths, bus byte order and AXI4-Lite codes.
// *********************************************************************

package lsu_pkg;

    // data and address word.
    typedef logic [31:0] word_t;

    // scalar access widths, encoded as in funct3.
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } access_t;

    // byte order of the data bus, "big" or "little".
    // little mirrors write lanes and byte-reverses word stores.
    localparam string BUS_ENDIANNESS = "little";

    // axi response code for a good transfer.
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // unprivileged, secure, data access.
    localparam logic [2:0] AXI_PROT_DATA = 3'b000;

endpackage

// File: lsu_top.sv
// *********************************************************************
// memory-access stage top
// load-store controller and axi4-lite bridge joined by the data bus,
// plus the instruction fence flush tracker. wiring only.
// *********************************************************************

`timescale 1ns/1ps

module lsu_top (
    input  logic             CLK,
    input  logic             nRST,
    // pipeline side.
    input  logic             ren,
    input  logic             wen,
    input  lsu_pkg::word_t   addr,
    input  lsu_pkg::access_t access,
    input  lsu_pkg::word_t   store_data,
    output lsu_pkg::word_t   load_data,
    output logic             ready,
    output logic             misaligned,
    output logic             bus_err,
    // fence and cache flush.
    input  logic             ifence,
    output logic             icache_flush,
    output logic             dcache_flush,
    input  logic             iflush_done,
    input  logic             dflush_done,
    output logic             fence_stall,
    // axi4-lite master.
    output lsu_pkg::word_t   awaddr,
    output logic [2:0]       awprot,
    output logic             awvalid,
    input  logic             awready,
    output lsu_pkg::word_t   wdata,
    output logic [3:0]       wstrb,
    output logic             wvalid,
    input  logic             wready,
    input  logic             bvalid,
    input  logic [1:0]       bresp,
    output logic             bready,
    output lsu_pkg::word_t   araddr,
    output logic [2:0]       arprot,
    output logic             arvalid,
    input  logic             arready,
    input  logic             rvalid,
    input  lsu_pkg::word_t   rdata,
    input  logic [1:0]       rresp,
    output logic             rready
);

    dbus_if dbus ();

    load_store_ctrl i_lsc (
        .CLK        (CLK),
        .nRST       (nRST),
        .ren        (ren),
        .wen        (wen),
        .addr       (addr),
        .access     (access),
        .store_data (store_data),
        .load_data  (load_data),
        .ready      (ready),
        .misaligned (misaligned),
        .bus_err    (bus_err),
        .bus        (dbus.controller)
    );

    fence_flush_tracker i_fence (
        .CLK          (CLK),
        .nRST         (nRST),
        .ifence       (ifence),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .fence_stall  (fence_stall)
    );

    dbus_axil_bridge i_bridge (
        .CLK     (CLK),
        .nRST    (nRST),
        .bus     (dbus.bridge),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .araddr  (araddr),
        .arprot  (arprot),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready)
    );

endmodule

// File: tb_axil_mem.sv
// **********************************************************************
// axi4-lite slave memory for the testbench
// byte-addressed memory with write strobes. every ready and response
// waits a random 0 to 3 cycles. addresses with top nibble e answer
// with slverr and leave memory alone.
// **********************************************************************

`timescale 1ns/1ps

module tb_axil_mem #(
    parameter int BYTES = 256,
    parameter int SEED  = 32'h8fb7
) (
    input  logic           CLK,
    input  logic           nRST,
    input  lsu_pkg::word_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  lsu_pkg::word_t wdata,
    input  logic [3:0]     wstrb,
    input  logic           wvalid,
    output logic           wready,
    output logic           bvalid,
    output logic [1:0]     bresp,
    input  logic           bready,
    input  lsu_pkg::word_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output logic           rvalid,
    output lsu_pkg::word_t rdata,
    output logic [1:0]     rresp,
    input  logic           rready
);

    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [7:0]     mem [BYTES];
    lsu_pkg::word_t aw_q;
    lsu_pkg::word_t ar_q;
    lsu_pkg::word_t wdata_q;
    logic [3:0]     wstrb_q;
    logic           aw_ok;
    logic           w_ok;
    logic           ar_ok;
    logic [1:0]     aw_wait;
    logic [1:0]     w_wait;
    logic [1:0]     b_wait;
    logic [1:0]     ar_wait;
    logic [1:0]     r_wait;
    integer         seed = SEED;

    // first byte of the addressed word.
    function automatic int word_index(lsu_pkg::word_t a);
        return int'(a & lsu_pkg::word_t'(BYTES - 4));
    endfunction

    function automatic logic err_addr(lsu_pkg::word_t a);
        return a[31:28] == 4'he;
    endfunction

    // one block for all channels keeps the random draws in a fixed order.
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= lsu_pkg::AXI_RESP_OKAY;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= lsu_pkg::AXI_RESP_OKAY;
            aw_ok   <= 1'b0;
            w_ok    <= 1'b0;
            ar_ok   <= 1'b0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
            b_wait  <= 2'd0;
            ar_wait <= 2'd0;
            r_wait  <= 2'd0;
            for (int i = 0; i < BYTES; i++)
                mem[i] <= 8'(i * 7 + 60);   // fill depends on the whole address.
        end else begin
            if (awready) begin
                awready <= 1'b0;
                aw_ok   <= 1'b1;
                aw_q    <= awaddr;
                aw_wait <= 2'($random(seed));
            end else if (awvalid && !aw_ok) begin
                if (aw_wait == 2'd0) awready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end
            if (wready) begin
                wready  <= 1'b0;
                w_ok    <= 1'b1;
                wdata_q <= wdata;
                wstrb_q <= wstrb;
                w_wait  <= 2'($random(seed));
            end else if (wvalid && !w_ok) begin
                if (w_wait == 2'd0) wready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end
            // write response once both halves are in.
            if (bvalid) begin
                if (bready) begin
                    bvalid <= 1'b0;
                    aw_ok  <= 1'b0;
                    w_ok   <= 1'b0;
                end
            end else if (aw_ok && w_ok) begin
                if (b_wait != 2'd0) begin
                    b_wait <= b_wait - 2'd1;
                end else begin
                    bvalid <= 1'b1;
                    bresp  <= err_addr(aw_q) ? RESP_SLVERR : lsu_pkg::AXI_RESP_OKAY;
                    b_wait <= 2'($random(seed));
                    for (int i = 0; i < 4; i++)
                        if (wstrb_q[i] && !err_addr(aw_q))
                            mem[word_index(aw_q) + i] <= wdata_q[8 * i +: 8];
                end
            end
            if (arready) begin
                arready <= 1'b0;
                ar_ok   <= 1'b1;
                ar_q    <= araddr;
                ar_wait <= 2'($random(seed));
            end else if (arvalid && !ar_ok) begin
                if (ar_wait == 2'd0) arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end
            if (rvalid) begin
                if (rready) begin
                    rvalid <= 1'b0;
                    ar_ok  <= 1'b0;
                end
            end else if (ar_ok) begin
                if (r_wait != 2'd0) begin
                    r_wait <= r_wait - 2'd1;
                end else begin
                    rvalid <= 1'b1;
                    rdata  <= {mem[word_index(ar_q) + 3], mem[word_index(ar_q) + 2],
                               mem[word_index(ar_q) + 1], mem[word_index(ar_q)]};
                    rresp  <= err_addr(ar_q) ? RESP_SLVERR : lsu_pkg::AXI_RESP_OKAY;
                    r_wait <= 2'($random(seed));
                end
            end
        end
    end

endmodule

// File: tb_lsu_top.sv
// **********************************************************************
// memory-access stage testbench
// directed tests for lane enables, store replication, load extension,
// misalignment, axi delays and errors, and the fence flush sequence.
// a byte array predicts memory with the little-endian lane mirroring.
// **********************************************************************

`timescale 1ns/1ps

module tb_lsu_top;

    localparam int HALF           = 20;     // 40 ns clock.
    localparam int MEM_BYTES      = 256;
    // about 80 accesses of up to 25 cycles, reset and fence steps, margin.
    localparam int TIMEOUT_CYCLES = 4000;

    logic             CLK;
    logic             nRST;
    logic             ren;
    logic             wen;
    lsu_pkg::word_t   addr;
    lsu_pkg::access_t access;
    lsu_pkg::word_t   store_data;
    lsu_pkg::word_t   load_data;
    logic             ready;
    logic             misaligned;
    logic             bus_err;
    logic             ifence;
    logic             icache_flush;
    logic             dcache_flush;
    logic             iflush_done;
    logic             dflush_done;
    logic             fence_stall;
    lsu_pkg::word_t   awaddr;
    logic [2:0]       awprot;
    logic             awvalid;
    logic             awready;
    lsu_pkg::word_t   wdata;
    logic [3:0]       wstrb;
    logic             wvalid;
    logic             wready;
    logic             bvalid;
    logic [1:0]       bresp;
    logic             bready;
    lsu_pkg::word_t   araddr;
    logic [2:0]       arprot;
    logic             arvalid;
    logic             arready;
    logic             rvalid;
    lsu_pkg::word_t   rdata;
    logic [1:0]       rresp;
    logic             rready;

    logic [7:0] ref_mem [MEM_BYTES];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         responses = 0;   // axi b and r handshakes seen.

    lsu_top i_dut (.*);

    tb_axil_mem #(.BYTES(MEM_BYTES)) i_mem (.*);

    always #HALF CLK = ~CLK;

    always @(posedge CLK) begin
        if ((bvalid && bready) || (rvalid && rready))
            responses <= responses + 1;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout, run still going after %0d cycles", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic expect_word(input string name, input lsu_pkg::word_t exp,
                               input lsu_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // write lanes land mirrored, word data byte-reversed.
    task automatic mirror_store(input lsu_pkg::access_t acc, input lsu_pkg::word_t a,
                                input lsu_pkg::word_t d);
        logic [3:0]     lanes;
        lsu_pkg::word_t bus_data;
        int             base;
        base = int'(a & lsu_pkg::word_t'(MEM_BYTES - 4));
        case (acc)
            lsu_pkg::LB: begin
                lanes    = 4'b0001 << a[1:0];
                bus_data = {4{d[7:0]}};
            end
            lsu_pkg::LH: begin
                lanes    = a[1] ? 4'b1100 : 4'b0011;
                bus_data = {2{d[15:0]}};
            end
            default: begin
                lanes    = 4'b1111;
                bus_data = {d[7:0], d[15:8], d[23:16], d[31:24]};
            end
        endcase
        for (int i = 0; i < 4; i++)
            if (lanes[i])
                ref_mem[base + 3 - i] = bus_data[8 * (3 - i) +: 8];
    endtask

    function automatic lsu_pkg::word_t predict_load(lsu_pkg::access_t acc,
                                                    lsu_pkg::word_t a);
        lsu_pkg::word_t w;
        logic [7:0]     b;
        logic [15:0]    h;
        int             base;
        base = int'(a & lsu_pkg::word_t'(MEM_BYTES - 4));
        w = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
        b = w[8 * int'(a[1:0]) +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (acc)
            lsu_pkg::LB:  return {{24{b[7]}}, b};
            lsu_pkg::LBU: return {24'd0, b};
            lsu_pkg::LH:  return {{16{h[15]}}, h};
            lsu_pkg::LHU: return {16'd0, h};
            default:      return w;
        endcase
    endfunction

    // one access from a falling edge until ready comes back.
    task automatic run_access(input logic write, input lsu_pkg::access_t acc,
                              input lsu_pkg::word_t a, input lsu_pkg::word_t d,
                              output lsu_pkg::word_t data, output logic err);
        int seen;
        seen       = responses;
        ren        = ~write;
        wen        = write;
        access     = acc;
        addr       = a;
        store_data = d;
        @(negedge CLK);
        if (ready !== 1'b0) begin
            errors++;
            $display("access to %h at %0t was not taken by the bridge", a, $time);
        end
        if (write)
            expect_word("awprot", lsu_pkg::word_t'(lsu_pkg::AXI_PROT_DATA),
                        lsu_pkg::word_t'(awprot));
        else
            expect_word("arprot", lsu_pkg::word_t'(lsu_pkg::AXI_PROT_DATA),
                        lsu_pkg::word_t'(arprot));
        while (ready !== 1'b1)
            @(negedge CLK);
        if (responses != seen + 1) begin
            errors++;
            $display("ready rose at %0t without exactly one axi response", $time);
        end
        data = load_data;
        err  = bus_err;
        @(negedge CLK);   // pipeline lets go one cycle after ready.
        if (ready !== 1'b1) begin
            errors++;
            $display("held request to %h started a second access at %0t", a, $time);
        end
        ren  = 1'b0;
        wen  = 1'b0;
        @(negedge CLK);   // idle cycle before the next request.
    endtask

    task automatic store_value(input lsu_pkg::access_t acc, input lsu_pkg::word_t a,
                               input lsu_pkg::word_t d);
        lsu_pkg::word_t data;
        logic           err;
        run_access(1'b1, acc, a, d, data, err);
        check_bit("bus_err", 1'b0, err);
        mirror_store(acc, a, d);
    endtask

    task automatic load_and_compare(input lsu_pkg::access_t acc, input lsu_pkg::word_t a);
        lsu_pkg::word_t data;
        logic           err;
        run_access(1'b0, acc, a, '0, data, err);
        check_bit("bus_err", 1'b0, err);
        expect_word("load_data", predict_load(acc, a), data);
    endtask

    task automatic check_reset_state();
        check_bit("awvalid", 1'b0, awvalid);
        check_bit("wvalid", 1'b0, wvalid);
        check_bit("arvalid", 1'b0, arvalid);
        check_bit("icache_flush", 1'b0, icache_flush);
        check_bit("dcache_flush", 1'b0, dcache_flush);
        check_bit("fence_stall", 1'b0, fence_stall);
        check_bit("ready", 1'b1, ready);
    endtask

    task automatic word_roundtrip();
        lsu_pkg::word_t data;
        logic           err;
        store_value(lsu_pkg::LW, 32'h10, 32'h1234_5678);
        run_access(1'b0, lsu_pkg::LW, 32'h10, '0, data, err);
        expect_word("load_data", 32'h7856_3412, data);   // bytes come back reversed.
        store_value(lsu_pkg::LW, 32'h24, 32'hdead_beef);
        load_and_compare(lsu_pkg::LW, 32'h24);
    endtask

    task automatic byte_half_lanes();
        for (int o = 0; o < 4; o++)
            store_value(lsu_pkg::LB, 32'h40 + o, {24'h0, 8'h91 + 8'(o * 37)});
        for (int o = 0; o < 4; o++) begin
            load_and_compare(lsu_pkg::LB, 32'h40 + o);
            load_and_compare(lsu_pkg::LBU, 32'h40 + o);
        end
        store_value(lsu_pkg::LH, 32'h50, 32'h0000_8a5c);
        store_value(lsu_pkg::LH, 32'h52, 32'hffff_3cf1);
        for (int o = 0; o < 4; o += 2) begin
            load_and_compare(lsu_pkg::LH, 32'h50 + o);
            load_and_compare(lsu_pkg::LHU, 32'h50 + o);
            load_and_compare(lsu_pkg::LB, 32'h51 + o);
        end
        load_and_compare(lsu_pkg::LW, 32'h50);
    endtask

    task automatic try_misaligned(input logic write, input lsu_pkg::access_t acc,
                                  input lsu_pkg::word_t a);
        ren        = ~write;
        wen        = write;
        access     = acc;
        addr       = a;
        store_data = 32'hffff_ffff;
        repeat (3) begin
            @(negedge CLK);
            check_bit("misaligned", 1'b1, misaligned);
            check_bit("ready", 1'b1, ready);
            if (awvalid || wvalid || arvalid) begin
                errors++;
                $display("axi valid raised at %0t for misaligned access to %h", $time, a);
            end
        end
        ren = 1'b0;
        wen = 1'b0;
        @(negedge CLK);
    endtask

    task automatic misaligned_blocked();
        store_value(lsu_pkg::LW, 32'h60, 32'hcafe_f00d);
        try_misaligned(1'b0, lsu_pkg::LH, 32'h61);
        try_misaligned(1'b0, lsu_pkg::LW, 32'h62);
        try_misaligned(1'b1, lsu_pkg::LH, 32'h63);
        try_misaligned(1'b1, lsu_pkg::LW, 32'h61);
        load_and_compare(lsu_pkg::LW, 32'h60);   // memory untouched.
    endtask

    task automatic delayed_and_error();
        lsu_pkg::word_t data;
        logic           err;
        for (int i = 0; i < 12; i++)
            store_value(lsu_pkg::LW, 32'h80 + 4 * i,
                        lsu_pkg::word_t'(i) * 32'h0101_0101 ^ 32'h5a5a_c3c3);
        for (int i = 0; i < 12; i++) begin
            load_and_compare(lsu_pkg::LW, 32'h80 + 4 * i);
            load_and_compare(lsu_pkg::LHU, 32'h82 + 4 * i);
        end
        run_access(1'b1, lsu_pkg::LW, 32'he000_0010, 32'h0bad_0bad, data, err);
        check_bit("bus_err", 1'b1, err);
        load_and_compare(lsu_pkg::LW, 32'h10);   // also clears bus_err.
    endtask

    task automatic fence_sequence(input logic i_first);
        ifence = 1'b1;
        #(HALF / 2);
        check_bit("icache_flush", 1'b1, icache_flush);
        check_bit("dcache_flush", 1'b1, dcache_flush);
        check_bit("fence_stall", 1'b0, fence_stall);
        @(negedge CLK);
        check_bit("icache_flush", 1'b0, icache_flush);
        check_bit("dcache_flush", 1'b0, dcache_flush);
        check_bit("fence_stall", 1'b1, fence_stall);
        iflush_done = i_first;
        dflush_done = ~i_first;
        @(negedge CLK);
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        check_bit("fence_stall", 1'b1, fence_stall);
        repeat (3) begin
            @(negedge CLK);
            check_bit("fence_stall", 1'b1, fence_stall);
            check_bit("icache_flush", 1'b0, icache_flush);
        end
        iflush_done = ~i_first;   // the later done.
        dflush_done = i_first;
        #(HALF / 2);
        check_bit("fence_stall", 1'b1, fence_stall);
        @(negedge CLK);
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        check_bit("fence_stall", 1'b0, fence_stall);
        ifence = 1'b0;
        @(negedge CLK);
    endtask

    initial begin
        CLK         = 1'b0;
        nRST        = 1'b0;
        ren         = 1'b0;
        wen         = 1'b0;
        addr        = '0;
        access      = lsu_pkg::LW;
        store_data  = '0;
        ifence      = 1'b0;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++)
            ref_mem[i] = 8'(i * 7 + 60);
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        check_reset_state();
        word_roundtrip();
        byte_half_lanes();
        misaligned_blocked();
        delayed_and_error();
        fence_sequence(1'b1);
        fence_sequence(1'b0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
